// File: rxBuffer.f
hw/rxBufferPkg.sv
hw/queueFifo.sv
hw/pushSteer.sv
hw/bufferPool.sv
hw/readMapper.sv
hw/rxBufferTop.sv
sim/rxBufferTb.sv

// File: Makefile
# Verilator build and run of the receive buffer testbench

VERILATOR ?= verilator
TOP       ?= rxBufferTb
FILELIST  ?= rxBuffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/rxBufferTb.sv
// Testbench for rxBufferTop with seeded random stimulus, reference model, checks and timeout

`timescale 1ns/10ps

module rxBufferTb;

   import rxBufferPkg::*;

   localparam int fifoDepth      = 8;
   localparam int emptyCycles    = numQueues;
   localparam int fillCycles     = 60;
   localparam int drainCycles    = numQueues * (fifoDepth + 1);
   localparam int pressureCycles = 2 * fifoDepth + 6;
   localparam int mixCycles      = 200;
   localparam int stimCycles     = 4 + 2 + emptyCycles + fillCycles + drainCycles
                                   + pressureCycles + mixCycles;
   localparam int timeoutLimit   = 2 * stimCycles + 100;

   logic                 clock;
   logic                 reset;
   logic                 pushValid;
   pushBeat              pushIn;
   logic                 pushReady;
   readReq               readIn;
   logic                 freshMapping;
   logic [dataWidth-1:0] readData;
   logic                 readValid;
   logic                 readHit;
   logic                 bufRegister;
   logic [2:0]           rgstrNum;
   logic                 bufRelease;
   logic [ptrBits-1:0]   rgstrPtr;
   logic [ptrBits-1:0]   lastNum;
   logic                 poolFull;
   logic                 poolEmpty;

   // Reference model
   logic [dataWidth-1:0] modelQ [numQueues][$];
   logic [queueBits-1:0] baseSlot;
   logic [ptrBits-1:0]   modelRgstr;
   logic [ptrBits-1:0]   modelRelease;
   logic [ptrBits-1:0]   modelFree;

   // Source side beat, held until accepted
   logic                 pendValid;
   pushBeat              pendBeat;

   string                testName;
   int                   cycleCount;

   rxBufferTop #(
      .fifoDepth (fifoDepth)
   ) dut0 (
      .clock        (clock),
      .reset        (reset),
      .pushValid    (pushValid),
      .pushIn       (pushIn),
      .pushReady    (pushReady),
      .readIn       (readIn),
      .freshMapping (freshMapping),
      .readData     (readData),
      .readValid    (readValid),
      .readHit      (readHit),
      .bufRegister  (bufRegister),
      .rgstrNum     (rgstrNum),
      .bufRelease   (bufRelease),
      .rgstrPtr     (rgstrPtr),
      .lastNum      (lastNum),
      .poolFull     (poolFull),
      .poolEmpty    (poolEmpty)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > timeoutLimit) begin
         $display("Run did not finish within %0d cycles", timeoutLimit);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // ========================================================================
   // Helpers
   // ========================================================================

   task automatic compare(input string what, input logic [dataWidth-1:0] expected,
                          input logic [dataWidth-1:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   function automatic logic [dataWidth-1:0] randomData();
      logic [dataWidth-1:0] word;
      for (int i = 0; i < dataWidth / 32; i++) begin
         word[i*32 +: 32] = $urandom;
      end
      return word;
   endfunction

   task automatic clearInputs();
      pushValid    = 1'b0;
      pushIn       = '0;
      readIn       = '0;
      freshMapping = 1'b0;
      bufRegister  = 1'b0;
      rgstrNum     = '0;
      bufRelease   = 1'b0;
   endtask

   task automatic newBeat(input logic [queueBits-1:0] queue);
      pendBeat.queue = queue;
      pendBeat.data  = randomData();
      pendValid      = 1'b1;
   endtask

   task automatic offerPush();
      if (!pendValid && ($urandom % 2 == 0)) begin
         newBeat(queueBits'($urandom % numQueues));
      end
      pushValid = pendValid;
      pushIn    = pendBeat;
   endtask

   task automatic issueRead(input logic [queueBits-1:0] offset);
      readIn.valid  = 1'b1;
      readIn.offset = offset;
   endtask

   // One clock: model update from the driven inputs, then registered outputs
   task automatic commitCycle();
      logic [queueBits-1:0] slot;
      logic                 ready;
      logic                 expValid;
      logic                 expHit;
      logic [dataWidth-1:0] expData;
      #1;
      ready = (modelQ[pushIn.queue].size() < fifoDepth);
      compare("pushReady", ready, pushReady);
      expValid = readIn.valid;
      expHit   = 1'b0;
      expData  = '0;
      if (readIn.valid) begin
         slot = baseSlot + readIn.offset;
         if (modelQ[slot].size() > 0) begin
            expHit  = 1'b1;
            expData = modelQ[slot].pop_front();
         end
      end
      if (pushValid && ready) begin
         modelQ[pushIn.queue].push_back(pushIn.data);
         pendValid = 1'b0;
      end
      if (freshMapping) begin
         baseSlot = modelRelease[queueBits-1:0];
      end
      if (bufRegister) begin
         modelRgstr = modelRgstr + ptrBits'(rgstrNum);
         modelFree  = modelFree - ptrBits'(rgstrNum);
      end
      if (bufRelease) begin
         modelRelease = modelRelease + 1'b1;
         modelFree    = modelFree + 1'b1;
      end
      @(negedge clock);
      compare("readValid", expValid, readValid);
      if (expValid) begin
         compare("readHit", expHit, readHit);
         compare("readData", expData, readData);
      end
      compare("rgstrPtr", modelRgstr, rgstrPtr);
      compare("lastNum", modelFree, lastNum);
      // Full pool has no free slot left, empty pool has all of them
      compare("poolFull", modelFree == '0, poolFull);
      compare("poolEmpty", modelFree == ptrBits'(numQueues), poolEmpty);
   endtask

   // ========================================================================
   // Stimulus
   // ========================================================================

   initial begin
      void'($urandom(32'he8d6365d));
      cycleCount   = 0;
      reset        = 1'b0;
      clearInputs();
      pendValid    = 1'b0;
      pendBeat     = '0;
      baseSlot     = '0;
      modelRgstr   = '0;
      modelRelease = '0;
      modelFree    = ptrBits'(numQueues);
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;

      testName = "reset";
      commitCycle();

      testName = "emptyRead";
      for (int off = 0; off < numQueues; off++) begin
         clearInputs();
         issueRead(queueBits'(off));
         commitCycle();
      end

      // Base stays zero, so offset equals queue
      testName = "pushOrder";
      for (int i = 0; i < fillCycles; i++) begin
         clearInputs();
         offerPush();
         commitCycle();
      end
      pendValid = 1'b0;
      for (int q = 0; q < numQueues; q++) begin
         for (int i = 0; i <= fifoDepth; i++) begin
            clearInputs();
            issueRead(queueBits'(q));
            commitCycle();
         end
      end

      testName = "backPressure";
      for (int i = 0; i < fifoDepth; i++) begin
         clearInputs();
         newBeat(4'd5);
         offerPush();
         commitCycle();
      end
      newBeat(4'd5);
      for (int i = 0; i < 3; i++) begin
         clearInputs();
         offerPush();
         commitCycle();
      end
      // Pop frees a slot, held beat goes in on the following edge
      clearInputs();
      offerPush();
      issueRead(4'd5);
      commitCycle();
      clearInputs();
      offerPush();
      commitCycle();
      for (int i = 0; i <= fifoDepth; i++) begin
         clearInputs();
         issueRead(4'd5);
         commitCycle();
      end

      testName = "mixedMapping";
      for (int i = 0; i < mixCycles; i++) begin
         clearInputs();
         offerPush();
         if ($urandom % 2 == 0) begin
            issueRead(queueBits'($urandom % numQueues));
         end
         freshMapping = ($urandom % 8 == 0);
         if ($urandom % 3 == 0) begin
            rgstrNum = 3'($urandom % 8);
            bufRegister = (ptrBits'(rgstrNum) <= modelFree);
         end
         if (($urandom % 3 == 0) && (modelRgstr != modelRelease)) begin
            bufRelease = 1'b1;
         end
         commitCycle();
      end
      pendValid = 1'b0;
      clearInputs();

      $display("TEST OK");
      $finish;
   end

endmodule

// File: hw/rxBufferTop.sv
// Receive buffer top level with push steering, per-queue FIFOs, read mapping and slot pool

`timescale 1ns/10ps

module rxBufferTop #(
   parameter int fifoDepth = 8
) (
   input  logic                             clock,
   input  logic                             reset,
   // Push side
   input  logic                             pushValid,
   input  rxBufferPkg::pushBeat             pushIn,
   output logic                             pushReady,
   // Host read side
   input  rxBufferPkg::readReq              readIn,
   input  logic                             freshMapping,
   output logic [rxBufferPkg::dataWidth-1:0] readData,
   output logic                             readValid,
   output logic                             readHit,
   // Slot pool
   input  logic                             bufRegister,
   input  logic [2:0]                       rgstrNum,
   input  logic                             bufRelease,
   output logic [rxBufferPkg::ptrBits-1:0]   rgstrPtr,
   output logic [rxBufferPkg::ptrBits-1:0]   lastNum,
   output logic                             poolFull,
   output logic                             poolEmpty
);

   import rxBufferPkg::*;

   logic [numQueues-1:0] pushStrobes;
   logic [numQueues-1:0] popStrobes;
   logic [numQueues-1:0] fullFlags;
   logic [numQueues-1:0] emptyFlags;
   logic [dataWidth-1:0] headData [numQueues];
   logic [ptrBits-1:0]   releasePtr;

   // ========================================================================
   // Push steering
   // ========================================================================

   pushSteer steer0 (
      .pushValid   (pushValid),
      .pushIn      (pushIn),
      .fullFlags   (fullFlags),
      .pushReady   (pushReady),
      .pushStrobes (pushStrobes)
   );

   // ========================================================================
   // Queue FIFOs
   // ========================================================================

   for (genvar q = 0; q < numQueues; q++) begin : queueGen
      queueFifo #(
         .fifoDepth (fifoDepth)
      ) fifo0 (
         .clock   (clock),
         .reset   (reset),
         .push    (pushStrobes[q]),
         .dataIn  (pushIn.data),
         .pop     (popStrobes[q]),
         .dataOut (headData[q]),
         .full    (fullFlags[q]),
         .empty   (emptyFlags[q])
      );
   end

   // ========================================================================
   // Read mapping
   // ========================================================================

   readMapper mapper0 (
      .clock        (clock),
      .reset        (reset),
      .readIn       (readIn),
      .freshMapping (freshMapping),
      .releasePtr   (releasePtr),
      .headData     (headData),
      .emptyFlags   (emptyFlags),
      .popStrobes   (popStrobes),
      .readData     (readData),
      .readValid    (readValid),
      .readHit      (readHit)
   );

   // Ledger also feeds the base slot
   bufferPool pool0 (
      .clock       (clock),
      .reset       (reset),
      .bufRegister (bufRegister),
      .rgstrNum    (rgstrNum),
      .bufRelease  (bufRelease),
      .rgstrPtr    (rgstrPtr),
      .releasePtr  (releasePtr),
      .lastNum     (lastNum),
      .poolFull    (poolFull),
      .poolEmpty   (poolEmpty)
   );

endmodule

// File: hw/readMapper.sv
// Read mapping from base slot and offset to a queue, single pop and registered response

`timescale 1ns/10ps

module readMapper (
   input  logic                             clock,
   input  logic                             reset,
   input  rxBufferPkg::readReq              readIn,
   input  logic                             freshMapping,
   input  logic [rxBufferPkg::ptrBits-1:0]   releasePtr,
   input  logic [rxBufferPkg::dataWidth-1:0] headData [rxBufferPkg::numQueues],
   input  logic [rxBufferPkg::numQueues-1:0] emptyFlags,
   output logic [rxBufferPkg::numQueues-1:0] popStrobes,
   output logic [rxBufferPkg::dataWidth-1:0] readData,
   output logic                             readValid,
   output logic                             readHit
);

   import rxBufferPkg::*;

   logic [queueBits-1:0] baseSlot;
   logic [queueBits-1:0] slot;
   logic                 hit;

   // ========================================================================
   // Base slot
   // ========================================================================

   // Slot index wraps with the pointer, so the lap bit is dropped
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         baseSlot <= '0;
      end else if (freshMapping) begin
         baseSlot <= releasePtr[queueBits-1:0];
      end
   end

   // Modulo numQueues falls out of the index width
   assign slot = baseSlot + readIn.offset;

   assign hit = readIn.valid & ~emptyFlags[slot];

   // ========================================================================
   // Pop
   // ========================================================================

   always_comb begin
      popStrobes = '0;
      for (int q = 0; q < numQueues; q++) begin
         if (hit && (slot == queueBits'(q))) begin
            popStrobes[q] = 1'b1;
         end
      end
   end

   // ========================================================================
   // Response
   // ========================================================================

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         readValid <= 1'b0;
         readHit   <= 1'b0;
      end else begin
         readValid <= readIn.valid;
         readHit   <= hit;
      end
   end

   // Miss returns zero data
   always_ff @(posedge clock) begin
      if (readIn.valid) begin
         readData <= hit ? headData[slot] : '0;
      end
   end

   singlePop: assert property (@(posedge clock) disable iff (!reset)
      $onehot0(popStrobes))
      else $error("readMapper pops more than one queue");

endmodule

// File: hw/bufferPool.sv
// Slot-pool ledger with register and release pointers, free count and full/empty flags

`timescale 1ns/10ps

module bufferPool (
   input  logic                           clock,
   input  logic                           reset,
   input  logic                           bufRegister,
   input  logic [2:0]                     rgstrNum,
   input  logic                           bufRelease,
   output logic [rxBufferPkg::ptrBits-1:0] rgstrPtr,
   output logic [rxBufferPkg::ptrBits-1:0] releasePtr,
   output logic [rxBufferPkg::ptrBits-1:0] lastNum,
   output logic                           poolFull,
   output logic                           poolEmpty
);

   import rxBufferPkg::*;

   logic [ptrBits-1:0] claimCount;
   logic [ptrBits-1:0] freeCount;
   logic [ptrBits-1:0] nextRgstrPtr;
   logic [ptrBits-1:0] nextReleasePtr;
   logic [ptrBits-1:0] nextLastNum;

   // ========================================================================
   // Next state
   // ========================================================================

   assign claimCount = bufRegister ? ptrBits'(rgstrNum) : '0;
   assign freeCount  = bufRelease ? ptrBits'(1) : '0;

   assign nextRgstrPtr   = rgstrPtr + claimCount;
   assign nextReleasePtr = releasePtr + freeCount;

   // Register and release in the same cycle both count
   assign nextLastNum = lastNum - claimCount + freeCount;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         rgstrPtr   <= '0;
         releasePtr <= '0;
         lastNum    <= ptrBits'(numQueues);
      end else begin
         rgstrPtr   <= nextRgstrPtr;
         releasePtr <= nextReleasePtr;
         lastNum    <= nextLastNum;
      end
   end

   // ========================================================================
   // Flags
   // ========================================================================

   // Same slot, different lap
   assign poolFull = (rgstrPtr[queueBits-1:0] == releasePtr[queueBits-1:0]) &&
                     (rgstrPtr[ptrBits-1] != releasePtr[ptrBits-1]);

   assign poolEmpty = (rgstrPtr == releasePtr);

   overRegister: assert property (@(posedge clock) disable iff (!reset)
      bufRegister |-> (ptrBits'(rgstrNum) <= lastNum))
      else $error("bufferPool registers more slots than are free");

   releaseEmpty: assert property (@(posedge clock) disable iff (!reset)
      bufRelease |-> !poolEmpty)
      else $error("bufferPool release on an empty pool");

endmodule

// File: hw/pushSteer.sv
// Push beat steering into one queue strobe, with ready from that queue's full flag

`timescale 1ns/10ps

module pushSteer (
   input  logic                             pushValid,
   input  rxBufferPkg::pushBeat             pushIn,
   input  logic [rxBufferPkg::numQueues-1:0] fullFlags,
   output logic                             pushReady,
   output logic [rxBufferPkg::numQueues-1:0] pushStrobes
);

   import rxBufferPkg::*;

   logic accept;

   // ========================================================================
   // Handshake
   // ========================================================================

   // Only the addressed queue can stall the source
   assign pushReady = ~fullFlags[pushIn.queue];

   assign accept = pushValid & pushReady;

   // ========================================================================
   // Queue decode
   // ========================================================================

   always_comb begin
      pushStrobes = '0;
      for (int q = 0; q < numQueues; q++) begin
         if (accept && (pushIn.queue == queueBits'(q))) begin
            pushStrobes[q] = 1'b1;
         end
      end
   end

endmodule

// File: hw/queueFifo.sv
// Per-queue FIFO with circular store, occupancy count, full and empty flags

`timescale 1ns/10ps

module queueFifo #(
   parameter int fifoDepth = 8
) (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             push,
   input  logic [rxBufferPkg::dataWidth-1:0] dataIn,
   input  logic                             pop,
   output logic [rxBufferPkg::dataWidth-1:0] dataOut,
   output logic                             full,
   output logic                             empty
);

   import rxBufferPkg::*;

   localparam int addrBits = $clog2(fifoDepth);

   logic [dataWidth-1:0] store [fifoDepth];
   logic [addrBits-1:0]  writePtr;
   logic [addrBits-1:0]  readPtr;
   logic [addrBits:0]    count;

   // ========================================================================
   // Storage
   // ========================================================================

   always_ff @(posedge clock) begin
      if (push) begin
         store[writePtr] <= dataIn;
      end
   end

   // Head word is visible without a pop
   assign dataOut = store[readPtr];

   // ========================================================================
   // Pointers and occupancy
   // ========================================================================

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         writePtr <= '0;
         readPtr  <= '0;
         count    <= '0;
      end else begin
         if (push) begin
            writePtr <= writePtr + 1'b1;
         end
         if (pop) begin
            readPtr <= readPtr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign full  = (count == (addrBits + 1)'(fifoDepth));
   assign empty = (count == '0);

   // Steering and mapping logic must never overrun or underrun a queue
   pushWhenFull: assert property (@(posedge clock) disable iff (!reset)
      push |-> !full)
      else $error("queueFifo push while full");

   popWhenEmpty: assert property (@(posedge clock) disable iff (!reset)
      pop |-> !empty)
      else $error("queueFifo pop while empty");

endmodule

// File: hw/rxBufferPkg.sv
// Width constants, push beat struct and read request struct for the receive buffer

package rxBufferPkg;

   // ========================================================================
   // Sizes
   // ========================================================================

   // One data beat
   localparam int dataWidth = 256;

   // Queues, FIFOs and pool slots
   localparam int numQueues = 16;
   localparam int queueBits = 4;

   // Extra top bit tells a full pool from an empty one
   localparam int ptrBits = queueBits + 1;

   // ========================================================================
   // Bundles
   // ========================================================================

   // Incoming beat tagged with its queue number
   typedef struct packed {
      logic [queueBits-1:0] queue;
      logic [dataWidth-1:0] data;
   } pushBeat;

   // Host read, offset counted from the base slot
   typedef struct packed {
      logic                 valid;
      logic [queueBits-1:0] offset;
   } readReq;

endpackage
